//--- design/reasm_config.svh
`ifndef REASM_CONFIG_SVH
`define REASM_CONFIG_SVH

// Segment fields
`define REASM_BUF_ID_WID   4
`define REASM_OFFSET_WID   16
`define REASM_SEG_LEN_WID  12

// Fragment pointers
// Pointer count equals table depth, two to the pointer width
`define REASM_FRAG_PTR_WID 3
`define REASM_NUM_FRAGS    8

`endif

//--- design/reasm_pkg.sv
`include "reasm_config.svh"

package reasm_pkg;

    // Incoming segment
    typedef struct packed {
        logic [`REASM_BUF_ID_WID-1:0]  buf_id;
        logic [`REASM_OFFSET_WID-1:0]  offset;
        logic [`REASM_SEG_LEN_WID-1:0] len;
        logic                          last;
    } seg_t;

    // --------------------
    // Table types
    // --------------------
    typedef struct packed {
        logic [`REASM_BUF_ID_WID-1:0] buf_id;
        logic [`REASM_OFFSET_WID-1:0] offset;
    } table_key_t;

    // Offset holds the far edge of the fragment
    typedef struct packed {
        logic [`REASM_FRAG_PTR_WID-1:0] ptr;
        logic [`REASM_OFFSET_WID-1:0]   offset;
    } table_value_t;

    typedef struct packed {
        logic         hit;
        table_value_t value;
    } lookup_result_t;

    // One insert and one delete per cycle
    typedef struct packed {
        logic         ins_valid;
        table_key_t   ins_key;
        table_value_t ins_value;
        logic         del_valid;
        table_key_t   del_key;
    } table_update_t;

    // --------------------
    // Fragment record
    // --------------------
    typedef enum logic [1:0] {
        FRAG_CREATE,
        FRAG_APPEND,
        FRAG_PREPEND,
        FRAG_MERGE
    } frag_action_e;

    typedef struct packed {
        frag_action_e                   action;
        logic [`REASM_BUF_ID_WID-1:0]   buf_id;
        logic                           last;
        logic [`REASM_FRAG_PTR_WID-1:0] ptr;
        logic [`REASM_OFFSET_WID-1:0]   offset_start;
        logic [`REASM_OFFSET_WID-1:0]   offset_end;
        logic [`REASM_FRAG_PTR_WID-1:0] merged_ptr;
    } frag_t;

endpackage : reasm_pkg

//--- design/segment_table.sv
`timescale 1ns/10ps

`include "reasm_config.svh"

module segment_table (
    input  logic                      clk,
    input  logic                      __srst,
    input  reasm_pkg::table_key_t     i_lookup_key,
    output reasm_pkg::lookup_result_t o_lookup,
    input  reasm_pkg::table_update_t  i_update
);
    localparam int NUM     = `REASM_NUM_FRAGS;
    localparam int IDX_WID = `REASM_FRAG_PTR_WID;

    // Entry storage
    logic [NUM-1:0]          entry_valid;
    reasm_pkg::table_key_t   entry_key [NUM];
    reasm_pkg::table_value_t entry_val [NUM];

    logic                    lookup_hit;
    logic [IDX_WID-1:0]      lookup_idx;
    logic                    del_hit;
    logic [IDX_WID-1:0]      del_idx;
    logic                    ins_match;
    logic [IDX_WID-1:0]      ins_match_idx;
    logic                    free_found;
    logic [IDX_WID-1:0]      free_idx;
    logic                    ins_ok;
    logic [IDX_WID-1:0]      ins_idx;

    // --------------------
    // Key search
    // --------------------
    // Walk downward so the lowest matching slot wins
    always_comb begin
        lookup_hit    = 1'b0;
        lookup_idx    = '0;
        del_hit       = 1'b0;
        del_idx       = '0;
        ins_match     = 1'b0;
        ins_match_idx = '0;
        free_found    = 1'b0;
        free_idx      = '0;
        for (int i = NUM - 1; i >= 0; i--) begin
            if (entry_valid[i]) begin
                if (entry_key[i] == i_lookup_key) begin
                    lookup_hit = 1'b1;
                    lookup_idx = IDX_WID'(i);
                end
                if (entry_key[i] == i_update.del_key) begin
                    del_hit = 1'b1;
                    del_idx = IDX_WID'(i);
                end
                if (entry_key[i] == i_update.ins_key) begin
                    ins_match     = 1'b1;
                    ins_match_idx = IDX_WID'(i);
                end
            end else begin
                free_found = 1'b1;
                free_idx   = IDX_WID'(i);
            end
        end
    end

    assign o_lookup.hit   = lookup_hit;
    assign o_lookup.value = lookup_hit ? entry_val[lookup_idx] : '0;

    // Overwrite on key match, else lowest free slot
    assign ins_idx = ins_match ? ins_match_idx : free_idx;
    assign ins_ok  = i_update.ins_valid && (ins_match || free_found);

    // --------------------
    // Update
    // --------------------
    // Insert follows delete, so it wins on a shared slot
    always_ff @(posedge clk) begin
        if (__srst) begin
            entry_valid <= '0;
        end else begin
            if (i_update.del_valid && del_hit) begin
                entry_valid[del_idx] <= 1'b0;
            end
            if (ins_ok) begin
                entry_valid[ins_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ins_ok) begin
            entry_key[ins_idx] <= i_update.ins_key;
            entry_val[ins_idx] <= i_update.ins_value;
        end
    end

endmodule : segment_table

//--- design/frag_ptr_alloc.sv
`timescale 1ns/10ps

`include "reasm_config.svh"

module frag_ptr_alloc (
    input  logic                           clk,
    input  logic                           __srst,
    input  logic                           i_alloc_req,
    output logic                           o_alloc_avail,
    output logic [`REASM_FRAG_PTR_WID-1:0] o_alloc_ptr,
    input  logic                           i_dealloc_valid,
    input  logic [`REASM_FRAG_PTR_WID-1:0] i_dealloc_ptr
);
    localparam int NUM     = `REASM_NUM_FRAGS;
    localparam int PTR_WID = `REASM_FRAG_PTR_WID;

    // One bit per pointer, set when free
    logic [NUM-1:0] free_bits;

    // Lowest free pointer
    always_comb begin
        o_alloc_avail = 1'b0;
        o_alloc_ptr   = '0;
        for (int i = NUM - 1; i >= 0; i--) begin
            if (free_bits[i]) begin
                o_alloc_avail = 1'b1;
                o_alloc_ptr   = PTR_WID'(i);
            end
        end
    end

    // --------------------
    // Free list update
    // --------------------
    // A returned pointer is never the one granted in the same cycle
    always_ff @(posedge clk) begin
        if (__srst) begin
            free_bits <= '1;
        end else begin
            if (i_dealloc_valid) begin
                free_bits[i_dealloc_ptr] <= 1'b1;
            end
            if (i_alloc_req && o_alloc_avail) begin
                free_bits[o_alloc_ptr] <= 1'b0;
            end
        end
    end

endmodule : frag_ptr_alloc

//--- design/frag_resolver.sv
`timescale 1ns/10ps

`include "reasm_config.svh"

module frag_resolver (
    input  logic                           clk,
    input  logic                           __srst,
    input  logic                           i_seg_valid,
    input  reasm_pkg::seg_t                i_seg,
    output reasm_pkg::table_key_t          o_append_key,
    output reasm_pkg::table_key_t          o_prepend_key,
    input  reasm_pkg::lookup_result_t      i_append_hit,
    input  reasm_pkg::lookup_result_t      i_prepend_hit,
    output reasm_pkg::table_update_t       o_append_update,
    output reasm_pkg::table_update_t       o_prepend_update,
    output logic                           o_alloc_req,
    input  logic                           i_alloc_avail,
    input  logic [`REASM_FRAG_PTR_WID-1:0] i_alloc_ptr,
    output logic                           o_frag_valid,
    output reasm_pkg::frag_t               o_frag
);
    localparam int OFFSET_WID = `REASM_OFFSET_WID;

    logic [OFFSET_WID-1:0] seg_end;
    logic                  frag_valid_nxt;
    reasm_pkg::frag_t      frag_nxt;

    assign seg_end = i_seg.offset + OFFSET_WID'(i_seg.len);

    // --------------------
    // Lookup keys
    // --------------------
    // Append side finds a fragment ending where this segment starts
    assign o_append_key.buf_id  = i_seg.buf_id;
    assign o_append_key.offset  = i_seg.offset;
    // Prepend side finds a fragment starting where this segment ends
    assign o_prepend_key.buf_id = i_seg.buf_id;
    assign o_prepend_key.offset = seg_end;

    // A pointer is only needed when neither table hits
    assign o_alloc_req = i_seg_valid && !i_append_hit.hit && !i_prepend_hit.hit;

    // --------------------
    // Action select
    // --------------------
    always_comb begin
        frag_nxt        = '0;
        frag_nxt.buf_id = i_seg.buf_id;
        frag_nxt.last   = i_seg.last;
        frag_valid_nxt  = i_seg_valid;
        case ({i_prepend_hit.hit, i_append_hit.hit})
            2'b01: begin
                frag_nxt.action       = reasm_pkg::FRAG_APPEND;
                frag_nxt.ptr          = i_append_hit.value.ptr;
                frag_nxt.offset_start = i_append_hit.value.offset;
                frag_nxt.offset_end   = seg_end;
            end
            2'b10: begin
                frag_nxt.action       = reasm_pkg::FRAG_PREPEND;
                frag_nxt.ptr          = i_prepend_hit.value.ptr;
                frag_nxt.offset_start = i_seg.offset;
                frag_nxt.offset_end   = i_prepend_hit.value.offset;
            end
            2'b11: begin
                // Later fragment survives, earlier one folds in
                frag_nxt.action       = reasm_pkg::FRAG_MERGE;
                frag_nxt.ptr          = i_prepend_hit.value.ptr;
                frag_nxt.merged_ptr   = i_append_hit.value.ptr;
                frag_nxt.offset_start = i_append_hit.value.offset;
                frag_nxt.offset_end   = i_prepend_hit.value.offset;
            end
            default: begin
                // Segment dropped when the free list is empty
                frag_nxt.action       = reasm_pkg::FRAG_CREATE;
                frag_nxt.ptr          = i_alloc_ptr;
                frag_nxt.offset_start = i_seg.offset;
                frag_nxt.offset_end   = seg_end;
                frag_valid_nxt        = i_seg_valid && i_alloc_avail;
            end
        endcase
    end

    // --------------------
    // Table updates
    // --------------------
    always_comb begin
        o_append_update  = '0;
        o_prepend_update = '0;

        o_append_update.ins_key.buf_id     = i_seg.buf_id;
        o_append_update.ins_key.offset     = frag_nxt.offset_end;
        o_append_update.ins_value.ptr      = frag_nxt.ptr;
        o_append_update.ins_value.offset   = frag_nxt.offset_start;
        o_append_update.del_key            = o_append_key;

        o_prepend_update.ins_key.buf_id    = i_seg.buf_id;
        o_prepend_update.ins_key.offset    = frag_nxt.offset_start;
        o_prepend_update.ins_value.ptr     = frag_nxt.ptr;
        o_prepend_update.ins_value.offset  = i_seg.last ? '0 : frag_nxt.offset_end;
        o_prepend_update.del_key           = o_prepend_key;

        if (frag_valid_nxt) begin
            // End entry, closed once the last segment arrives
            if ((frag_nxt.action == reasm_pkg::FRAG_CREATE) ||
                (frag_nxt.action == reasm_pkg::FRAG_APPEND)) begin
                o_append_update.ins_valid = !i_seg.last;
            end else begin
                o_append_update.ins_valid = (frag_nxt.offset_end != '0);
            end
            o_prepend_update.ins_valid = (frag_nxt.offset_start != '0);

            // Old edges that the new segment covers
            o_append_update.del_valid  = (frag_nxt.action == reasm_pkg::FRAG_APPEND) ||
                                         (frag_nxt.action == reasm_pkg::FRAG_MERGE);
            o_prepend_update.del_valid = (frag_nxt.action == reasm_pkg::FRAG_PREPEND) ||
                                         (frag_nxt.action == reasm_pkg::FRAG_MERGE);
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk) begin
        if (__srst) begin
            o_frag_valid <= 1'b0;
        end else begin
            o_frag_valid <= frag_valid_nxt;
        end
    end

    always_ff @(posedge clk) begin
        o_frag <= frag_nxt;
    end

endmodule : frag_resolver

//--- design/reasm_cache.sv
`timescale 1ns/10ps

`include "reasm_config.svh"

module reasm_cache (
    input  logic                           clk,
    input  logic                           __srst,
    input  logic                           i_seg_valid,
    input  reasm_pkg::seg_t                i_seg,
    input  logic                           i_dealloc_valid,
    input  logic [`REASM_FRAG_PTR_WID-1:0] i_dealloc_ptr,
    output logic                           o_frag_valid,
    output reasm_pkg::frag_t               o_frag
);

    // Lookup paths
    reasm_pkg::table_key_t          append_key;
    reasm_pkg::table_key_t          prepend_key;
    reasm_pkg::lookup_result_t      append_hit;
    reasm_pkg::lookup_result_t      prepend_hit;

    // Update paths
    reasm_pkg::table_update_t       append_update;
    reasm_pkg::table_update_t       prepend_update;

    // Pointer grant
    logic                           alloc_req;
    logic                           alloc_avail;
    logic [`REASM_FRAG_PTR_WID-1:0] alloc_ptr;

    // --------------------
    // Fragment end table
    // --------------------
    segment_table u_append_table (
        .clk          ( clk ),
        .__srst       ( __srst ),
        .i_lookup_key ( append_key ),
        .o_lookup     ( append_hit ),
        .i_update     ( append_update )
    );

    // --------------------
    // Fragment start table
    // --------------------
    segment_table u_prepend_table (
        .clk          ( clk ),
        .__srst       ( __srst ),
        .i_lookup_key ( prepend_key ),
        .o_lookup     ( prepend_hit ),
        .i_update     ( prepend_update )
    );

    // --------------------
    // Pointer free list
    // --------------------
    frag_ptr_alloc u_frag_ptr_alloc (
        .clk             ( clk ),
        .__srst          ( __srst ),
        .i_alloc_req     ( alloc_req ),
        .o_alloc_avail   ( alloc_avail ),
        .o_alloc_ptr     ( alloc_ptr ),
        .i_dealloc_valid ( i_dealloc_valid ),
        .i_dealloc_ptr   ( i_dealloc_ptr )
    );

    // --------------------
    // Resolver
    // --------------------
    frag_resolver u_frag_resolver (
        .clk              ( clk ),
        .__srst           ( __srst ),
        .i_seg_valid      ( i_seg_valid ),
        .i_seg            ( i_seg ),
        .o_append_key     ( append_key ),
        .o_prepend_key    ( prepend_key ),
        .i_append_hit     ( append_hit ),
        .i_prepend_hit    ( prepend_hit ),
        .o_append_update  ( append_update ),
        .o_prepend_update ( prepend_update ),
        .o_alloc_req      ( alloc_req ),
        .i_alloc_avail    ( alloc_avail ),
        .i_alloc_ptr      ( alloc_ptr ),
        .o_frag_valid     ( o_frag_valid ),
        .o_frag           ( o_frag )
    );

endmodule : reasm_cache

//--- testbench/reasm_cache_tb.sv
`timescale 1ns/10ps

`include "reasm_config.svh"

module reasm_cache_tb;

    localparam int NUM_ROWS   = 16;
    localparam int TIMEOUT_NS = (NUM_ROWS * 5 + 20) * 8;

    // One stimulus row with its expected response
    typedef struct packed {
        logic                           dealloc_valid;
        logic [`REASM_FRAG_PTR_WID-1:0] dealloc_ptr;
        logic                           seg_valid;
        reasm_pkg::seg_t                seg;
        logic                           no_gap;
        logic                           exp_valid;
        reasm_pkg::frag_t               exp_frag;
    } row_t;

    logic                           clk = 1'b0;
    logic                           __srst;
    logic                           i_seg_valid;
    reasm_pkg::seg_t                i_seg;
    logic                           i_dealloc_valid;
    logic [`REASM_FRAG_PTR_WID-1:0] i_dealloc_ptr;
    logic                           o_frag_valid;
    reasm_pkg::frag_t               o_frag;

    row_t        rows [NUM_ROWS];
    string       row_names [NUM_ROWS];
    int          row_count   = 0;
    int          error_count = 0;
    int          check_count = 0;
    logic [31:0] lfsr_state  = 32'hf474;

    always #4 clk = ~clk;

    reasm_cache DUT (
        .clk             ( clk ),
        .__srst          ( __srst ),
        .i_seg_valid     ( i_seg_valid ),
        .i_seg           ( i_seg ),
        .i_dealloc_valid ( i_dealloc_valid ),
        .i_dealloc_ptr   ( i_dealloc_ptr ),
        .o_frag_valid    ( o_frag_valid ),
        .o_frag          ( o_frag )
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // Two bits per gap, one step per bit
    task automatic draw_gap(output int gap);
        gap = 0;
        for (int b = 0; b < 2; b++) begin
            gap        = gap * 2 + (lfsr_state[0] ? 1 : 0);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic reasm_pkg::seg_t make_seg(input int buf_id, input int offset,
                                                 input int len, input int last);
        reasm_pkg::seg_t s;
        s.buf_id = `REASM_BUF_ID_WID'(buf_id);
        s.offset = `REASM_OFFSET_WID'(offset);
        s.len    = `REASM_SEG_LEN_WID'(len);
        s.last   = 1'(last);
        return s;
    endfunction

    function automatic reasm_pkg::frag_t make_frag(input reasm_pkg::frag_action_e action,
                                                   input int buf_id, input int last,
                                                   input int ptr, input int start,
                                                   input int stop, input int merged);
        reasm_pkg::frag_t f;
        f.action       = action;
        f.buf_id       = `REASM_BUF_ID_WID'(buf_id);
        f.last         = 1'(last);
        f.ptr          = `REASM_FRAG_PTR_WID'(ptr);
        f.offset_start = `REASM_OFFSET_WID'(start);
        f.offset_end   = `REASM_OFFSET_WID'(stop);
        f.merged_ptr   = `REASM_FRAG_PTR_WID'(merged);
        return f;
    endfunction

    task automatic add_row(input string name, input logic dv, input int dp, input logic sv,
                           input reasm_pkg::seg_t seg, input logic no_gap,
                           input logic ev, input reasm_pkg::frag_t ef);
        rows[row_count].dealloc_valid = dv;
        rows[row_count].dealloc_ptr   = `REASM_FRAG_PTR_WID'(dp);
        rows[row_count].seg_valid     = sv;
        rows[row_count].seg           = seg;
        rows[row_count].no_gap        = no_gap;
        rows[row_count].exp_valid     = ev;
        rows[row_count].exp_frag      = ef;
        row_names[row_count]          = name;
        row_count++;
    endtask

    function automatic string frag_to_text(input reasm_pkg::frag_t f);
        reasm_pkg::frag_action_e act;
        act = f.action;
        return $sformatf("%s buf %0d last %0b ptr %0d start %0d end %0d merged %0d",
                         act.name(), f.buf_id, f.last, f.ptr, f.offset_start,
                         f.offset_end, f.merged_ptr);
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_valid(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            $display("error %s: o_frag_valid expected %0b actual %0b", name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_frag(input string name, input reasm_pkg::frag_t exp,
                              input reasm_pkg::frag_t act);
        check_count++;
        if (act !== exp) begin
            $display("error %s: o_frag expected %s actual %s", name,
                     frag_to_text(exp), frag_to_text(act));
            error_count++;
        end
    endtask

    task automatic drive_row(input row_t r);
        i_dealloc_valid = r.dealloc_valid;
        i_dealloc_ptr   = r.dealloc_ptr;
        i_seg_valid     = r.seg_valid;
        i_seg           = r.seg;
    endtask

    task automatic clear_inputs();
        i_dealloc_valid = 1'b0;
        i_dealloc_ptr   = '0;
        i_seg_valid     = 1'b0;
        i_seg           = '0;
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    task automatic build_table();
        add_row("create_first", 1'b0, 0, 1'b1, make_seg(1, 100, 20, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_CREATE, 1, 0, 0, 100, 120, 0));
        add_row("create_second", 1'b0, 0, 1'b1, make_seg(2, 1000, 50, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_CREATE, 2, 0, 1, 1000, 1050, 0));
        add_row("append_first", 1'b0, 0, 1'b1, make_seg(1, 120, 30, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_APPEND, 1, 0, 0, 100, 150, 0));
        // Back to back with the previous append
        add_row("append_second", 1'b0, 0, 1'b1, make_seg(1, 150, 10, 0), 1'b1,
                1'b1, make_frag(reasm_pkg::FRAG_APPEND, 1, 0, 0, 100, 160, 0));
        add_row("prepend", 1'b0, 0, 1'b1, make_seg(2, 980, 20, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_PREPEND, 2, 0, 1, 980, 1050, 0));
        add_row("merge_left", 1'b0, 0, 1'b1, make_seg(3, 200, 40, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_CREATE, 3, 0, 2, 200, 240, 0));
        add_row("merge_right", 1'b0, 0, 1'b1, make_seg(3, 300, 50, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_CREATE, 3, 0, 3, 300, 350, 0));
        add_row("gap_other_buf", 1'b0, 0, 1'b1, make_seg(4, 240, 60, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_CREATE, 4, 0, 4, 240, 300, 0));
        add_row("merge_fill", 1'b0, 0, 1'b1, make_seg(3, 240, 60, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_MERGE, 3, 0, 3, 200, 350, 2));
        add_row("append_last", 1'b0, 0, 1'b1, make_seg(1, 160, 40, 1), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_APPEND, 1, 1, 0, 100, 200, 0));
        // End entry of a closed fragment must be gone next cycle
        add_row("after_last", 1'b0, 0, 1'b1, make_seg(1, 200, 10, 0), 1'b1,
                1'b1, make_frag(reasm_pkg::FRAG_CREATE, 1, 0, 5, 200, 210, 0));
        add_row("fill_ptr6", 1'b0, 0, 1'b1, make_seg(5, 10, 5, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_CREATE, 5, 0, 6, 10, 15, 0));
        add_row("fill_ptr7", 1'b0, 0, 1'b1, make_seg(6, 10, 5, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_CREATE, 6, 0, 7, 10, 15, 0));
        add_row("exhausted", 1'b0, 0, 1'b1, make_seg(7, 10, 5, 0), 1'b0,
                1'b0, '0);
        add_row("dealloc_ptr5", 1'b1, 5, 1'b0, make_seg(0, 0, 0, 0), 1'b0,
                1'b0, '0);
        add_row("reuse_ptr5", 1'b0, 0, 1'b1, make_seg(7, 10, 5, 0), 1'b0,
                1'b1, make_frag(reasm_pkg::FRAG_CREATE, 7, 0, 5, 10, 15, 0));
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin : stimulus
        int gap;
        __srst = 1'b1;
        clear_inputs();
        build_table();
        repeat (9) @(posedge clk);
        #1;
        // Segment strobe held across the last reset edge
        i_seg_valid = 1'b1;
        i_seg       = make_seg(1, 100, 20, 0);
        @(posedge clk);
        #1;
        check_valid("during_reset", 1'b0, o_frag_valid);
        clear_inputs();
        __srst = 1'b0;

        for (int i = 0; i < row_count; i++) begin
            drive_row(rows[i]);
            @(posedge clk);
            #1;
            clear_inputs();
            check_valid(row_names[i], rows[i].exp_valid, o_frag_valid);
            if (rows[i].exp_valid) begin
                check_frag(row_names[i], rows[i].exp_frag, o_frag);
            end
            gap = 0;
            if ((i + 1 < row_count) && !rows[i + 1].no_gap) begin
                draw_gap(gap);
            end
            // No output expected while idle
            repeat (gap) begin
                @(posedge clk);
                #1;
                check_valid({row_names[i], "_idle"}, 1'b0, o_frag_valid);
            end
        end

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the test sequence did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule : reasm_cache_tb

//--- build.f
+incdir+design
design/reasm_pkg.sv
design/segment_table.sv
design/frag_ptr_alloc.sv
design/frag_resolver.sv
design/reasm_cache.sv
testbench/reasm_cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module reasm_cache_tb -f build.f \
    && sim_out="$(obj_dir/Vreasm_cache_tb)" \
    && echo "$sim_out" \
    && grep -q "^Simulation passed$" <<< "$sim_out" \
    && echo "Run result: PASS" \
    || { echo "Run result: FAIL"; exit 1; }
